// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - design/dcache_pkg.sv
      - design/line_xfer_if.sv
      - design/dcache_tag_array.sv
      - design/dcache_data_array.sv
      - design/dcache_ctrl.sv
      - design/axi_line_master.sv
      - design/dcache_top.sv
  - target: test
    files:
      - tests/dcache_asserts.sv
      - tests/dcache_tb.sv

// ==== dcache.f ====
design/dcache_pkg.sv
design/line_xfer_if.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_ctrl.sv
design/axi_line_master.sv
design/dcache_top.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv

// ==== design/axi_line_master.sv ====
`timescale 1ns/1ps

module axi_line_master (
    input  logic        clk,
    input  logic        rst,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic        rvalid,
    input  logic        awready,
    input  logic        wready,
    input  logic        bvalid,
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        arvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic [2:0]  awsize,
    output logic [1:0]  awburst,
    output logic        awvalid,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    output logic        bready,
    line_xfer_if.burst  xfer
);

    logic [dcache_pkg::WORD_BITS-1:0] r_beat_q;
    logic [dcache_pkg::WORD_BITS-1:0] w_beat_q;

    assign araddr  = xfer.line_addr;
    assign arlen   = dcache_pkg::AXI_LEN_LINE;
    assign arsize  = dcache_pkg::AXI_SIZE_WORD;
    assign arburst = dcache_pkg::AXI_BURST_INCR;
    assign rready  = 1'b1;

    assign awaddr  = xfer.line_addr;
    assign awlen   = dcache_pkg::AXI_LEN_LINE;
    assign awsize  = dcache_pkg::AXI_SIZE_WORD;
    assign awburst = dcache_pkg::AXI_BURST_INCR;
    assign wstrb   = 4'b1111;
    assign bready  = 1'b1;

    // Beats leave in address order
    assign wdata = xfer.wr_line[w_beat_q*32 +: 32];
    // Beat counter wraps to zero as the last beat is taken
    assign wlast = (w_beat_q == dcache_pkg::WORD_BITS'(dcache_pkg::LINE_WORDS - 1));

    // Read burst
    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid  <= 1'b0;
            r_beat_q <= '0;
        end else begin
            if (xfer.rd_start) begin
                arvalid  <= 1'b1;
                r_beat_q <= '0;
            end else if (arready) begin
                arvalid <= 1'b0;
            end
            if (rvalid)
                r_beat_q <= r_beat_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid)
            xfer.rd_line[r_beat_q*32 +: 32] <= rdata;
    end

    // Write burst, data phase starts after the address is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            w_beat_q <= '0;
        end else begin
            if (xfer.wr_start) begin
                awvalid <= 1'b1;
            end else if (awvalid && awready) begin
                awvalid  <= 1'b0;
                wvalid   <= 1'b1;
                w_beat_q <= '0;
            end else if (wvalid && wready) begin
                w_beat_q <= w_beat_q + 1'b1;
                if (wlast)
                    wvalid <= 1'b0;
            end
        end
    end

    // End of either burst
    always_ff @(posedge clk) begin
        if (rst)
            xfer.done <= 1'b0;
        else
            xfer.done <= (rvalid && rlast) || bvalid;
    end

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req_valid,
    input  logic                               req_store,
    input  logic [31:0]                        req_addr,
    input  logic [31:0]                        req_wdata,
    input  logic [3:0]                         req_wstrb,
    output logic                               req_ready,
    output logic                               resp_valid,
    output logic [31:0]                        resp_rdata,
    output dcache_pkg::dcache_addr_t           lookup_addr,
    input  logic                               hit,
    input  logic [dcache_pkg::WAY_BITS-1:0]    hit_way,
    input  logic [dcache_pkg::WAY_BITS-1:0]    victim_way,
    input  logic                               victim_dirty,
    input  logic [dcache_pkg::TAG_BITS-1:0]    victim_tag,
    output logic                               tag_fill_en,
    output logic                               set_dirty,
    output logic                               clear_dirty,
    output logic [dcache_pkg::WAY_BITS-1:0]    data_way,
    output logic                               data_rd_en,
    output logic                               data_fill_en,
    output logic                               store_en,
    output logic [31:0]                        store_data,
    output logic [3:0]                         store_strb,
    input  logic [dcache_pkg::LINE_BITS-1:0]   rd_line,
    input  logic [31:0]                        rd_word,
    line_xfer_if.ctrl                          xfer
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_FILL,
        ST_RESPOND
    } state_t;

    state_t                   state_q;
    logic                     ready_q;
    logic                     busy_q;
    dcache_pkg::dcache_addr_t addr_q;
    dcache_pkg::dcache_addr_t line_addr;
    logic                     store_q;
    logic [31:0]              wdata_q;
    logic [3:0]               wstrb_q;

    // Accepted request is held until the response
    always_ff @(posedge clk) begin
        if (req_valid && ready_q) begin
            addr_q.addr <= req_addr;
            store_q     <= req_store;
            wdata_q     <= req_wdata;
            wstrb_q     <= req_wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            ready_q <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_valid && ready_q) begin
                        ready_q <= 1'b0;
                        state_q <= ST_LOOKUP;
                    end else begin
                        ready_q <= 1'b1;
                    end
                end
                ST_LOOKUP: begin
                    if (hit)
                        state_q <= ST_RESPOND;
                    else if (victim_dirty)
                        state_q <= ST_WRITEBACK;
                    else
                        state_q <= ST_REFILL;
                end
                // One burst per state, started on entry and left on done
                ST_WRITEBACK, ST_REFILL: begin
                    if (xfer.done) begin
                        busy_q  <= 1'b0;
                        state_q <= (state_q == ST_WRITEBACK) ? ST_REFILL : ST_FILL;
                    end else begin
                        busy_q <= 1'b1;
                    end
                end
                ST_FILL:    state_q <= ST_LOOKUP;
                ST_RESPOND: state_q <= ST_IDLE;
                default:    state_q <= ST_IDLE;
            endcase
        end
    end

    // Write-back goes to the victim's line, refill to the requested line
    always_comb begin
        line_addr                 = addr_q;
        line_addr.fields.word     = '0;
        line_addr.fields.byte_off = '0;
        if (state_q == ST_WRITEBACK)
            line_addr.fields.tag = victim_tag;
    end

    assign xfer.line_addr = line_addr.addr;
    assign xfer.wr_line   = rd_line;
    assign xfer.wr_start  = (state_q == ST_WRITEBACK) && !busy_q;
    assign xfer.rd_start  = (state_q == ST_REFILL) && !busy_q;

    assign req_ready   = ready_q;
    assign resp_valid  = (state_q == ST_RESPOND);
    assign resp_rdata  = rd_word;
    assign lookup_addr = addr_q;

    // Miss reads the victim line, hit reads the requested word
    assign data_way     = (state_q == ST_LOOKUP && hit) ? hit_way : victim_way;
    assign data_rd_en   = (state_q == ST_LOOKUP);
    assign store_en     = (state_q == ST_LOOKUP) && hit && store_q;
    assign store_data   = wdata_q;
    assign store_strb   = wstrb_q;
    assign set_dirty    = store_en;
    assign clear_dirty  = (state_q == ST_WRITEBACK) && xfer.done;
    assign tag_fill_en  = (state_q == ST_FILL);
    assign data_fill_en = (state_q == ST_FILL);

endmodule

// ==== design/dcache_data_array.sv ====
`timescale 1ns/1ps

module dcache_data_array (
    input  logic                               clk,
    input  dcache_pkg::dcache_addr_t           addr,
    input  logic [dcache_pkg::WAY_BITS-1:0]    way,
    input  logic                               rd_en,
    input  logic                               fill_en,
    input  logic [dcache_pkg::LINE_BITS-1:0]   fill_line,
    input  logic                               store_en,
    input  logic [31:0]                        store_data,
    input  logic [3:0]                         store_strb,
    output logic [31:0]                        rd_word,
    output logic [dcache_pkg::LINE_BITS-1:0]   rd_line
);

    logic [dcache_pkg::LINE_BITS-1:0] lines [dcache_pkg::NUM_WAYS * dcache_pkg::NUM_SETS];
    logic [dcache_pkg::WAY_BITS+dcache_pkg::SET_BITS-1:0] idx;
    logic [dcache_pkg::LINE_BITS-1:0] merged_line;

    assign idx = {way, addr.fields.set};

    // Byte lanes of the store replace the addressed word in place
    always_comb begin
        merged_line = lines[idx];
        for (int b = 0; b < 4; b++) begin
            if (store_en && store_strb[b])
                merged_line[addr.fields.word*32 + b*8 +: 8] = store_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en)
            lines[idx] <= fill_line;
        else if (store_en)
            lines[idx] <= merged_line;
    end

    // Read returns the new data when a store hits in the same cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_line <= merged_line;
            rd_word <= merged_line[addr.fields.word*32 +: 32];
        end
    end

endmodule

// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    // Cache geometry
    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 16;
    localparam int LINE_WORDS = 4;

    localparam int WAY_BITS  = $clog2(NUM_WAYS);
    localparam int SET_BITS  = $clog2(NUM_SETS);
    localparam int WORD_BITS = $clog2(LINE_WORDS);
    localparam int TAG_BITS  = 32 - SET_BITS - WORD_BITS - 2;
    localparam int LINE_BITS = LINE_WORDS * 32;

    // Fixed AXI burst shape, one cache line of 32-bit beats
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
    localparam logic [7:0] AXI_LEN_LINE   = 8'(LINE_WORDS - 1);

    typedef struct packed {
        logic [TAG_BITS-1:0]  tag;
        logic [SET_BITS-1:0]  set;
        logic [WORD_BITS-1:0] word;
        logic [1:0]           byte_off;
    } dcache_addr_fields_t;

    // Same 32-bit address, seen whole or split into cache fields
    typedef union packed {
        logic [31:0]         addr;
        dcache_addr_fields_t fields;
    } dcache_addr_t;

endpackage

// ==== design/dcache_tag_array.sv ====
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic                              clk,
    input  logic                              rst,
    input  dcache_pkg::dcache_addr_t          lookup_addr,
    input  logic                              fill_en,
    input  logic                              set_dirty,
    input  logic                              clear_dirty,
    output logic                              hit,
    output logic [dcache_pkg::WAY_BITS-1:0]   hit_way,
    output logic [dcache_pkg::WAY_BITS-1:0]   victim_way,
    output logic                              victim_dirty,
    output logic [dcache_pkg::TAG_BITS-1:0]   victim_tag
);

    logic [dcache_pkg::TAG_BITS-1:0] tag_mem [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] valid_q;
    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] dirty_q;
    logic [dcache_pkg::WAY_BITS-1:0] rr_q;
    logic [dcache_pkg::NUM_WAYS-1:0] way_hit;
    logic [dcache_pkg::SET_BITS-1:0] set_idx;

    assign set_idx = lookup_addr.fields.set;

    // Tag compare of every way in the addressed set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            way_hit[w] = valid_q[w][set_idx] &&
                         (tag_mem[w][set_idx] == lookup_addr.fields.tag);
            if (way_hit[w])
                hit_way = w[dcache_pkg::WAY_BITS-1:0];
        end
    end

    assign hit          = |way_hit;
    assign victim_way   = rr_q;
    assign victim_dirty = dirty_q[rr_q][set_idx];
    assign victim_tag   = tag_mem[rr_q][set_idx];

    always_ff @(posedge clk) begin
        if (fill_en)
            tag_mem[rr_q][set_idx] <= lookup_addr.fields.tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            rr_q    <= '0;
        end else begin
            // A fill lands in the victim way, then the pointer moves on
            if (fill_en) begin
                valid_q[rr_q][set_idx] <= 1'b1;
                dirty_q[rr_q][set_idx] <= 1'b0;
                rr_q                   <= rr_q + 1'b1;
            end
            if (set_dirty)
                dirty_q[hit_way][set_idx] <= 1'b1;
            // Victim has been written back to memory
            if (clear_dirty)
                dirty_q[rr_q][set_idx] <= 1'b0;
        end
    end

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  logic        req_store,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    input  logic [3:0]  req_wstrb,
    output logic        req_ready,
    output logic        resp_valid,
    output logic [31:0] resp_rdata,
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic [2:0]  awsize,
    output logic [1:0]  awburst,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready
);

    dcache_pkg::dcache_addr_t         lookup_addr;
    logic                             hit;
    logic [dcache_pkg::WAY_BITS-1:0]  hit_way;
    logic [dcache_pkg::WAY_BITS-1:0]  victim_way;
    logic                             victim_dirty;
    logic [dcache_pkg::TAG_BITS-1:0]  victim_tag;
    logic                             tag_fill_en;
    logic                             set_dirty;
    logic                             clear_dirty;
    logic [dcache_pkg::WAY_BITS-1:0]  data_way;
    logic                             data_rd_en;
    logic                             data_fill_en;
    logic                             store_en;
    logic [31:0]                      store_data;
    logic [3:0]                       store_strb;
    logic [31:0]                      rd_word;
    logic [dcache_pkg::LINE_BITS-1:0] rd_line;

    line_xfer_if xfer ();

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_store   (req_store),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag),
        .tag_fill_en (tag_fill_en),
        .set_dirty   (set_dirty),
        .clear_dirty (clear_dirty),
        .data_way    (data_way),
        .data_rd_en  (data_rd_en),
        .data_fill_en(data_fill_en),
        .store_en    (store_en),
        .store_data  (store_data),
        .store_strb  (store_strb),
        .rd_line     (rd_line),
        .rd_word     (rd_word),
        .xfer        (xfer.ctrl)
    );

    dcache_tag_array u_tags (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill_en     (tag_fill_en),
        .set_dirty   (set_dirty),
        .clear_dirty (clear_dirty),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag)
    );

    dcache_data_array u_data (
        .clk       (clk),
        .addr      (lookup_addr),
        .way       (data_way),
        .rd_en     (data_rd_en),
        .fill_en   (data_fill_en),
        .fill_line (xfer.rd_line),
        .store_en  (store_en),
        .store_data(store_data),
        .store_strb(store_strb),
        .rd_word   (rd_word),
        .rd_line   (rd_line)
    );

    axi_line_master u_axi (
        .clk    (clk),
        .rst    (rst),
        .arready(arready),
        .rdata  (rdata),
        .rlast  (rlast),
        .rvalid (rvalid),
        .awready(awready),
        .wready (wready),
        .bvalid (bvalid),
        .araddr (araddr),
        .arlen  (arlen),
        .arsize (arsize),
        .arburst(arburst),
        .arvalid(arvalid),
        .rready (rready),
        .awaddr (awaddr),
        .awlen  (awlen),
        .awsize (awsize),
        .awburst(awburst),
        .awvalid(awvalid),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .wlast  (wlast),
        .wvalid (wvalid),
        .bready (bready),
        .xfer   (xfer.burst)
    );

endmodule

// ==== design/line_xfer_if.sv ====
`timescale 1ns/1ps

interface line_xfer_if;

    logic                              rd_start;
    logic                              wr_start;
    logic [31:0]                       line_addr;
    logic [dcache_pkg::LINE_BITS-1:0]  wr_line;
    logic [dcache_pkg::LINE_BITS-1:0]  rd_line;
    logic                              done;

    // Controller side issues the start pulses and waits for done
    modport ctrl (
        output rd_start, wr_start, line_addr, wr_line,
        input  rd_line, done
    );

    modport burst (
        input  rd_start, wr_start, line_addr, wr_line,
        output rd_line, done
    );

endinterface

// ==== tests/dcache_asserts.sv ====
`timescale 1ns/1ps

module dcache_asserts (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_ready,
    input logic resp_valid,
    input logic arvalid,
    input logic arready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic wlast
);

    int fail_count = 0;

    // Address requests stay up until the slave takes them
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else begin
            fail_count++;
            $error("arvalid dropped before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else begin
            fail_count++;
            $error("awvalid dropped before awready");
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else begin
            fail_count++;
            $error("wvalid dropped before wready");
        end

    wlast_valid: assert property (@(posedge clk) disable iff (rst)
        wlast |-> wvalid)
        else begin
            fail_count++;
            $error("wlast high without wvalid");
        end

    // One request in flight, so no response while a new one is taken
    resp_not_accept: assert property (@(posedge clk) disable iff (rst)
        !(resp_valid && req_valid && req_ready))
        else begin
            fail_count++;
            $error("resp_valid on the same cycle as an accepted request");
        end

endmodule

bind dcache_top dcache_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .resp_valid(resp_valid),
    .arvalid   (arvalid),
    .arready   (arready),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .wlast     (wlast)
);

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

    localparam int MEM_WORDS    = 1024;
    localparam int RESET_CYCLES = 10;
    localparam int ROW_CYCLES   = 60;

    typedef struct {
        bit          store;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        int          ar_delta;
        int          aw_delta;
    } stim_row_t;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_store;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_wstrb;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [31:0] rdata = '0;
    logic        rlast = 1'b0;
    logic        rvalid = 1'b0;
    logic        rready;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic [2:0]  awsize;
    logic [1:0]  awburst;
    logic        awvalid;
    logic        awready = 1'b0;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready = 1'b0;
    logic        bvalid = 1'b0;
    logic        bready;

    stim_row_t   stim_table[$];
    logic [31:0] mem_word [MEM_WORDS];
    logic [31:0] ref_word [MEM_WORDS];
    bit          random_ready = 1'b0;
    int          ar_count = 0;
    int          aw_count = 0;
    int          cycle = 0;
    int          timeout_limit = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          rd_model_errs = 0;
    int          wr_model_errs = 0;
    bit          r_busy = 1'b0;
    int          r_base = 0;
    int          r_beat = 0;
    bit          w_active = 1'b0;
    int          w_base = 0;
    int          w_beat = 0;

    dcache_top UUT (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Memory contents after reset, unique for every byte address
    function automatic logic [31:0] init_word(input int idx);
        logic [31:0] byte_addr;
        byte_addr = idx * 4;
        return byte_addr ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    function automatic logic draw_ready();
        if (!random_ready)
            return 1'b1;
        return (($urandom % 3) == 0);
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (timeout_limit > 0 && cycle >= timeout_limit) begin
            $display("Timeout: no response within %0d cycles", timeout_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // AXI read slave, four beats back to back after the address
    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            r_busy  <= 1'b0;
            r_beat  <= 0;
        end else begin
            arready <= draw_ready();
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            if (r_busy) begin
                rvalid <= 1'b1;
                rdata  <= mem_word[r_base + r_beat];
                rlast  <= (r_beat == 3);
                r_beat <= r_beat + 1;
                if (r_beat == 3)
                    r_busy <= 1'b0;
            end else if (arvalid && arready) begin
                if (araddr[3:0] !== 4'h0 || arlen !== 8'h03) begin
                    $display("CHECK FAILED araddr/arlen: got %h/%h expected line aligned/03",
                             araddr, arlen);
                    rd_model_errs++;
                end
                if (arsize !== 3'h2 || arburst !== 2'h1) begin
                    $display("CHECK FAILED arsize/arburst: got %h/%h expected 2/1",
                             arsize, arburst);
                    rd_model_errs++;
                end
                if (rready !== 1'b1) begin
                    $display("rready is not held high at the start of a read burst");
                    rd_model_errs++;
                end
                r_base   <= araddr[11:2];
                r_beat   <= 0;
                r_busy   <= 1'b1;
                ar_count <= ar_count + 1;
            end
        end
    end

    // AXI write slave, checks each beat against the reference contents
    always @(posedge clk) begin
        if (rst) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            w_active <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++)
                mem_word[i] <= init_word(i);
        end else begin
            awready <= draw_ready();
            wready  <= draw_ready();
            bvalid  <= 1'b0;
            if (awvalid && awready && !w_active) begin
                if (awaddr[3:0] !== 4'h0 || awlen !== 8'h03 || awsize !== 3'h2 ||
                    awburst !== 2'h1) begin
                    $display("CHECK FAILED awaddr/awlen/awsize/awburst: got %h/%h/%h/%h",
                             awaddr, awlen, awsize, awburst);
                    wr_model_errs++;
                end
                w_base   <= awaddr[11:2];
                w_beat   <= 0;
                w_active <= 1'b1;
                aw_count <= aw_count + 1;
            end
            if (wvalid && wready) begin
                if (!w_active) begin
                    $display("Write data beat arrived before its write address");
                    wr_model_errs++;
                end
                if (wdata !== ref_word[w_base + w_beat]) begin
                    $display("CHECK FAILED wdata beat %0d: got %h expected %h", w_beat,
                             wdata, ref_word[w_base + w_beat]);
                    wr_model_errs++;
                end
                if (wstrb !== 4'hf || wlast !== (w_beat == 3)) begin
                    $display("CHECK FAILED wstrb/wlast: got %h/%h at beat %0d", wstrb,
                             wlast, w_beat);
                    wr_model_errs++;
                end
                if (bready !== 1'b1) begin
                    $display("bready is not held high during a write burst");
                    wr_model_errs++;
                end
                mem_word[w_base + w_beat] <= wdata;
                w_beat <= w_beat + 1;
                if (wlast) begin
                    w_active <= 1'b0;
                    bvalid   <= 1'b1;
                end
            end
        end
    end

    task automatic add_row(input bit store, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, input int ar_delta, input int aw_delta);
        stim_row_t row;
        row.store    = store;
        row.addr     = addr;
        row.wdata    = wdata;
        row.strb     = strb;
        row.ar_delta = ar_delta;
        row.aw_delta = aw_delta;
        stim_table.push_back(row);
    endtask

    // Victim choice follows one round-robin pointer shared by all sets
    task automatic build_table();
        add_row(0, 32'h0000_0004, 32'h0, 4'h0, 1, 0);
        add_row(0, 32'h0000_0004, 32'h0, 4'h0, 0, 0);
        add_row(0, 32'h0000_000C, 32'h0, 4'h0, 0, 0);
        add_row(1, 32'h0000_0008, 32'h1122_3344, 4'b0101, 0, 0);
        add_row(0, 32'h0000_0008, 32'h0, 4'h0, 0, 0);
        add_row(0, 32'h0000_0104, 32'h0, 4'h0, 1, 0);
        add_row(0, 32'h0000_0208, 32'h0, 4'h0, 1, 1);
        add_row(0, 32'h0000_0008, 32'h0, 4'h0, 1, 0);
        add_row(1, 32'h0000_0014, 32'hDEAD_BEEF, 4'b1111, 1, 0);
        add_row(1, 32'h0000_0018, 32'hCAFE_0000, 4'b1100, 0, 0);
        add_row(0, 32'h0000_0314, 32'h0, 4'h0, 1, 0);
        add_row(0, 32'h0000_0414, 32'h0, 4'h0, 1, 1);
        add_row(0, 32'h0000_0018, 32'h0, 4'h0, 1, 0);
        add_row(0, 32'h0000_0014, 32'h0, 4'h0, 0, 0);
        add_row(1, 32'h0000_0004, 32'h0000_5A00, 4'b0010, 0, 0);
        add_row(0, 32'h0000_0204, 32'h0, 4'h0, 0, 0);
        add_row(0, 32'h0000_0504, 32'h0, 4'h0, 1, 0);
        add_row(0, 32'h0000_0604, 32'h0, 4'h0, 1, 1);
        add_row(0, 32'h0000_0004, 32'h0, 4'h0, 1, 0);
        add_row(0, 32'h0000_0008, 32'h0, 4'h0, 0, 0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        req_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        if (req_ready || resp_valid || arvalid || awvalid || wvalid || wlast) begin
            $display("Outputs are not low while reset is held");
            other_errs++;
        end
        rst <= 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_word[i] = init_word(i);
        repeat (2) @(posedge clk);
        if (!req_ready) begin
            $display("req_ready did not rise after reset");
            other_errs++;
        end
    endtask

    task automatic run_row(input int n);
        stim_row_t   row;
        int          idx;
        int          ar_start;
        int          aw_start;
        int          accept_cycle;
        logic [31:0] expected;
        row = stim_table[n];
        idx = row.addr[11:2];
        if (row.store)
            ref_word[idx] = merge_bytes(ref_word[idx], row.wdata, row.strb);
        expected  = ref_word[idx];
        ar_start  = ar_count;
        aw_start  = aw_count;
        req_valid <= 1'b1;
        req_store <= row.store;
        req_addr  <= row.addr;
        req_wdata <= row.wdata;
        req_wstrb <= row.strb;
        @(posedge clk);
        while (!req_ready)
            @(posedge clk);
        accept_cycle = cycle;
        req_valid <= 1'b0;
        @(posedge clk);
        while (!resp_valid)
            @(posedge clk);
        if (resp_rdata !== expected) begin
            $display("CHECK FAILED resp_rdata row %0d: got %h expected %h", n, resp_rdata,
                     expected);
            value_errs++;
        end
        if (ar_count - ar_start != row.ar_delta) begin
            $display("CHECK FAILED ar_count delta row %0d: got %h expected %h", n,
                     ar_count - ar_start, row.ar_delta);
            value_errs++;
        end
        if (aw_count - aw_start != row.aw_delta) begin
            $display("CHECK FAILED aw_count delta row %0d: got %h expected %h", n,
                     aw_count - aw_start, row.aw_delta);
            value_errs++;
        end
        // Hits answer two cycles after the accepting edge
        if (row.ar_delta == 0 && row.aw_delta == 0 && cycle - accept_cycle != 2) begin
            $display("CHECK FAILED hit latency row %0d: got %h expected %h", n,
                     cycle - accept_cycle, 2);
            value_errs++;
        end
    endtask

    initial begin
        int total_errs;
        void'($urandom(72));
        rst       = 1'b1;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        build_table();
        timeout_limit = 2 * (stim_table.size() * ROW_CYCLES + 2 * RESET_CYCLES);
        // Same table with ready always high, then with random ready delays
        for (int pass = 0; pass < 2; pass++) begin
            random_ready <= (pass == 1);
            apply_reset();
            for (int n = 0; n < stim_table.size(); n++)
                run_row(n);
        end
        total_errs = value_errs + other_errs + rd_model_errs + wr_model_errs +
                     UUT.u_asserts.fail_count;
        $display("Errors: %0d value, %0d protocol, %0d read model, %0d write model, %0d assertion",
                 value_errs, other_errs, rd_model_errs, wr_model_errs,
                 UUT.u_asserts.fail_count);
        if (total_errs == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
